/* sim/apb_sub_input.txt */
# test  op  address  wdata  expected
# op is write, read or err; expected is checked on reads only
mac0_wr       write 00A10000 11112222 00000000
mac0_rd       read  00A10000 00000000 11112222
mac1_wr       write 00A20004 33334444 00000000
mac1_wr_top   write 00A2003C 0F0F0F0F 00000000
mac1_rd       read  00A20004 00000000 33334444
mac1_rd_top   read  00A2003C 00000000 0F0F0F0F
mac2_wr       write 00A30010 A5A5A5A5 00000000
mac2_rd       read  00A30010 00000000 A5A5A5A5
mac3_wr       write 00A40008 DEADBEEF 00000000
mac3_wr_again write 00A40008 CAFEF00D 00000000
mac3_rd       read  00A40008 00000000 CAFEF00D
alut_e2_wr    write 00A00008 00001234 00000000
alut_e3_wr    write 00A0000C 0000BEEF 00000000
alut_e5_wr    write 00A00014 00001234 00000000
alut_e3_rd    read  00A0000C 00000000 0000BEEF
alut_e5_rd    read  00A00014 00000000 00001234
alut_gap_rd   read  00A00028 00000000 00000000
alut_top_rd   read  00A0007C 00000000 00000000
alut_key_dup  write 00A00020 00001234 00000000
alut_res_dup  read  00A00024 00000000 00000102
alut_key_one  write 00A00020 0000BEEF 00000000
alut_res_one  read  00A00024 00000000 00000103
alut_key_miss write 00A00020 00005555 00000000
alut_res_miss read  00A00024 00000000 00000000
bad_high      err   00B00000 00000000 00000000
bad_low       err   009FFFFC 00000000 00000000
after_err     read  00A10000 00000000 11112222

/* src.f */
common/apb_sub_pkg.sv
ahb2apb/ahb2apb_ctrl.sv
ahb2apb/apb_slot_router.sv
alut/alut_regs.sv
src/apb_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_apb_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_apb_subsystem
RTL_TOP   ?= apb_subsystem
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_apb_subsystem.sv */
// APB subsystem testbench
`timescale 1ns/1ns

module tb_apb_subsystem;

   // ----------------------------------------
   // Address map and encodings
   // ----------------------------------------

   localparam logic [31:0] MAP_BASE   = 32'h00A0_0000;
   localparam int          MAP_SLOTS  = 5;
   // Upper bound for any single wait loop
   localparam int          WAIT_LIMIT = 20;
   localparam logic [1:0]  OKAY       = 2'b00;
   localparam logic [1:0]  ERROR      = 2'b01;
   // Op tokens as they appear in the data file
   localparam logic [63:0] OP_WRITE   = {24'h0, "write"};
   localparam logic [63:0] OP_READ    = {32'h0, "read"};
   localparam logic [63:0] OP_ERR     = {40'h0, "err"};

   logic        clk;
   logic        rst;
   // AHB master side
   logic        hsel;
   logic [31:0] haddr;
   logic [1:0]  htrans;
   logic        hwrite;
   logic [31:0] hwdata;
   logic        hready_in;
   wire  [31:0] hrdata;
   wire         hready;
   wire  [1:0]  hresp;
   // Shared APB signals
   wire  [31:0] paddr;
   wire         pwrite;
   wire         penable;
   wire  [31:0] pwdata;
   wire  [3:0]  psel_mac;
   // MAC register models
   logic [31:0] prdata_mac [4];
   logic [3:0]  pready_mac = 4'hF;
   logic [31:0] mac_mem [4][16];
   int          wait_left [4] = '{default: 0};
   logic [31:0] rng_state = 32'd9;
   // Run bookkeeping
   int          tests;
   int          failed;
   int          errors;
   logic        stop_run;

   tb_clock_gen clk_gen_i (
      .clk (clk),
      .rst (rst)
   );

   apb_subsystem dut_i (
      .hclk        (clk),
      .rst         (rst),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .penable     (penable),
      .pwdata      (pwdata),
      .prdata_mac0 (prdata_mac[0]),
      .psel_mac0   (psel_mac[0]),
      .pready_mac0 (pready_mac[0]),
      .prdata_mac1 (prdata_mac[1]),
      .psel_mac1   (psel_mac[1]),
      .pready_mac1 (pready_mac[1]),
      .prdata_mac2 (prdata_mac[2]),
      .psel_mac2   (psel_mac[2]),
      .pready_mac2 (pready_mac[2]),
      .prdata_mac3 (prdata_mac[3]),
      .psel_mac3   (psel_mac[3]),
      .pready_mac3 (pready_mac[3])
   );

   // 32-bit xorshift step
   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Slot number of an address or -1 outside the map
   function automatic int slot_of(input logic [31:0] a);
      logic [31:0] ofs;
      ofs = a - MAP_BASE;
      if (a < MAP_BASE || ofs[31:16] >= 16'(MAP_SLOTS)) begin
         return -1;
      end
      return int'(ofs[31:16]);
   endfunction

   // ----------------------------------------
   // MAC slave models
   // ----------------------------------------

   // Word index from paddr bits 5:2
   always_comb begin
      for (int n = 0; n < 4; n++) begin
         prdata_mac[n] = mac_mem[n][paddr[5:2]];
      end
   end

   always @(posedge clk) begin
      logic [3:0]  sel_q;
      logic        en_q;
      logic        wr_q;
      logic        rst_q;
      logic [3:0]  idx_q;
      logic [31:0] wd_q;
      // Bus state as the DUT saw it at this edge
      sel_q = psel_mac;
      en_q  = penable;
      wr_q  = pwrite;
      rst_q = rst;
      idx_q = paddr[5:2];
      wd_q  = pwdata;
      #1;
      if (rst_q) begin
         // Fill word depends on slot and index
         for (int m = 0; m < 4; m++) begin
            for (int w = 0; w < 16; w++) begin
               mac_mem[m][w] = 32'hC0DE_0000 | 32'(m * 16 + w);
            end
            wait_left[m] = 0;
         end
         pready_mac = 4'hF;
      end else begin
         for (int n = 0; n < 4; n++) begin
            if (sel_q[n] && !en_q) begin
               // Draw 0 to 3 wait states in the setup phase
               rng_state    = next_random(rng_state);
               wait_left[n] = int'(rng_state[1:0]);
            end else if (sel_q[n] && en_q) begin
               if (pready_mac[n]) begin
                  if (wr_q) begin
                     mac_mem[n][idx_q] = wd_q;
                  end
               end else begin
                  wait_left[n] = wait_left[n] - 1;
               end
            end
            pready_mac[n] = (wait_left[n] == 0);
         end
      end
   end

   // ----------------------------------------
   // AHB master
   // ----------------------------------------

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // One single transfer with the response sampled each cycle
   task automatic ahb_transfer(input logic [31:0] addr, input logic wr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic [3:0] psel_seen, output int low_cycles,
                               output int err_low, output logic [1:0] resp_done,
                               output logic done);
      int n;
      psel_seen  = 4'b0000;
      low_cycles = 0;
      err_low    = 0;
      rdata      = 32'h0;
      resp_done  = OKAY;
      n = 0;
      while (!hready && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      done = hready;
      if (done) begin
         // NONSEQ address phase
         hsel   = 1'b1;
         htrans = 2'b10;
         haddr  = addr;
         hwrite = wr;
         next_cycle();
         // Data phase
         hsel   = 1'b0;
         htrans = 2'b00;
         hwdata = wdata;
         n = 0;
         while (!hready && n < WAIT_LIMIT) begin
            psel_seen = psel_seen | psel_mac;
            if (hresp === ERROR) begin
               err_low++;
            end
            low_cycles++;
            next_cycle();
            n++;
         end
         psel_seen = psel_seen | psel_mac;
         resp_done = hresp;
         rdata     = hrdata;
         done      = hready;
      end
   endtask

   // Run one data file line and print its result
   task automatic test_line(input logic [8*24-1:0] name, input logic [63:0] op,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_data);
      int          exp_slot;
      int          low_cycles;
      int          err_low;
      logic        test_ok;
      logic        done;
      logic [1:0]  resp_done;
      logic [3:0]  psel_seen;
      logic [3:0]  exp_psel;
      logic [31:0] rdata;
      test_ok  = 1'b1;
      exp_slot = slot_of(addr);
      // Slot 0 is the ALUT with no external select
      exp_psel = (exp_slot >= 1) ? 4'(1 << (exp_slot - 1)) : 4'b0000;
      if (op != OP_WRITE && op != OP_READ && op != OP_ERR) begin
         $display("%0s: unknown operation in the data file", name);
         test_ok = 1'b0;
         errors++;
      end else begin
         ahb_transfer(addr, op == OP_WRITE, wdata, rdata, psel_seen, low_cycles,
                      err_low, resp_done, done);
         if (!done) begin
            $display("%0s: hready stayed low for %0d cycles", name, WAIT_LIMIT);
            test_ok  = 1'b0;
            stop_run = 1'b1;
            errors++;
         end else if (op == OP_ERR) begin
            // One cycle low with ERROR and then one high with ERROR
            if (low_cycles != 1 || err_low != 1) begin
               $display("%0s: error response had %0d low cycles, %0d of them with ERROR",
                        name, low_cycles, err_low);
               test_ok = 1'b0;
               errors++;
            end
            if (resp_done !== ERROR) begin
               $display("error %0s: expected hresp %h, actual %h", name, ERROR, resp_done);
               test_ok = 1'b0;
               errors++;
            end
            if (psel_seen !== 4'b0000) begin
               $display("error %0s: expected psel_mac %b, actual %b", name, 4'b0000, psel_seen);
               test_ok = 1'b0;
               errors++;
            end
            next_cycle();
            if (hresp !== OKAY) begin
               $display("error %0s: expected hresp %h after error, actual %h", name, OKAY, hresp);
               test_ok = 1'b0;
               errors++;
            end
         end else begin
            if (resp_done !== OKAY) begin
               $display("error %0s: expected hresp %h, actual %h", name, OKAY, resp_done);
               test_ok = 1'b0;
               errors++;
            end
            if (err_low != 0) begin
               $display("%0s: ERROR response during a mapped transfer", name);
               test_ok = 1'b0;
               errors++;
            end
            // Three cycles plus at most three wait states
            if (low_cycles < 3 || low_cycles > 6) begin
               $display("%0s: latency of %0d cycles is outside 3 to 6", name, low_cycles);
               test_ok = 1'b0;
               errors++;
            end
            if (psel_seen !== exp_psel) begin
               $display("error %0s: expected psel_mac %b, actual %b", name, exp_psel, psel_seen);
               test_ok = 1'b0;
               errors++;
            end
            if (op == OP_READ && rdata !== exp_data) begin
               $display("error %0s: expected %h, actual %h", name, exp_data, rdata);
               test_ok = 1'b0;
               errors++;
            end
         end
      end
      tests++;
      if (test_ok) begin
         $display("pass  %0s", name);
      end else begin
         failed++;
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------

   initial begin
      int               fd;
      int               cnt;
      int               n;
      logic [8*24-1:0]  name;
      logic [63:0]      op;
      logic [31:0]      addr;
      logic [31:0]      wdata;
      logic [31:0]      exp_data;
      logic [8*128-1:0] line_buf;
      // Idle AHB master
      hsel      = 1'b0;
      haddr     = 32'h0;
      htrans    = 2'b00;
      hwrite    = 1'b0;
      hwdata    = 32'h0;
      hready_in = 1'b1;
      tests     = 0;
      failed    = 0;
      errors    = 0;
      stop_run  = 1'b0;
      next_cycle();
      n = 0;
      while (rst && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (rst) begin
         $display("reset still high after %0d cycles", WAIT_LIMIT);
         stop_run = 1'b1;
         errors++;
      end else begin
         tests++;
         if (hready !== 1'b1 || hresp !== OKAY || psel_mac !== 4'b0000 || penable !== 1'b0) begin
            // Fields are hready, hresp, psel_mac and penable
            $display("error after_reset: expected %b %b %b %b, actual %b %b %b %b",
                     1'b1, OKAY, 4'b0000, 1'b0, hready, hresp, psel_mac, penable);
            failed++;
            errors++;
         end else begin
            $display("pass  after_reset");
         end
      end
      fd = $fopen("sim/apb_sub_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open sim/apb_sub_input.txt");
         errors++;
      end else begin
         while (!stop_run && !$feof(fd)) begin
            line_buf = '0;
            cnt = $fgets(line_buf, fd);
            if (cnt != 0) begin
               cnt = $sscanf(line_buf, "%s %s %h %h %h", name, op, addr, wdata, exp_data);
               // Comment and blank lines give fewer fields
               if (cnt == 5) begin
                  test_line(name, op, addr, wdata, exp_data);
               end
            end
         end
         $fclose(fd);
      end
      $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* sim/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held for eight rising edges, released just after the edge
   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

/* src/apb_subsystem.sv */
// APB peripheral subsystem top
`timescale 1ns/1ns

module apb_subsystem (
   input  wire                       hclk,
   input  wire                       rst,
   // AHB-Lite slave port
   input  wire                       hsel,
   input  apb_sub_pkg::addr_t        haddr,
   input  wire [1:0]                 htrans,
   input  wire                       hwrite,
   input  apb_sub_pkg::data_t        hwdata,
   input  wire                       hready_in,
   output apb_sub_pkg::data_t        hrdata,
   output wire                       hready,
   output apb_sub_pkg::resp_t        hresp,
   // Shared APB master signals
   output apb_sub_pkg::addr_t        paddr,
   output wire                       pwrite,
   output wire                       penable,
   output apb_sub_pkg::data_t        pwdata,
   // MAC0 APB port
   input  apb_sub_pkg::data_t        prdata_mac0,
   output wire                       psel_mac0,
   input  wire                       pready_mac0,
   // MAC1 APB port
   input  apb_sub_pkg::data_t        prdata_mac1,
   output wire                       psel_mac1,
   input  wire                       pready_mac1,
   // MAC2 APB port
   input  apb_sub_pkg::data_t        prdata_mac2,
   output wire                       psel_mac2,
   input  wire                       pready_mac2,
   // MAC3 APB port
   input  apb_sub_pkg::data_t        prdata_mac3,
   output wire                       psel_mac3,
   input  wire                       pready_mac3
);

   // ----------------------------------------
   // Internal wiring
   // ----------------------------------------

   wire                addr_hit;
   wire                psel_active;
   wire                sel_ready;
   wire                psel_alut;
   apb_sub_pkg::data_t sel_rdata;
   apb_sub_pkg::data_t prdata_alut;

   // Bridge state machine and APB sequencing
   ahb2apb_ctrl ctrl_i (
      .hclk        (hclk),
      .rst         (rst),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .addr_hit    (addr_hit),
      .sel_rdata   (sel_rdata),
      .sel_ready   (sel_ready),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .penable     (penable),
      .psel_active (psel_active)
   );

   // Slot 0 ALUT, slots 1 to 4 MAC0 to MAC3
   apb_slot_router router_i (
      .haddr       (haddr),
      .paddr       (paddr),
      .psel_active (psel_active),
      .prdata_alut (prdata_alut),
      .prdata_mac0 (prdata_mac0),
      .prdata_mac1 (prdata_mac1),
      .prdata_mac2 (prdata_mac2),
      .prdata_mac3 (prdata_mac3),
      .pready_mac0 (pready_mac0),
      .pready_mac1 (pready_mac1),
      .pready_mac2 (pready_mac2),
      .pready_mac3 (pready_mac3),
      .addr_hit    (addr_hit),
      .psel        ({psel_mac3, psel_mac2, psel_mac1, psel_mac0, psel_alut}),
      .sel_rdata   (sel_rdata),
      .sel_ready   (sel_ready)
   );

   // On-chip lookup table, low address bits only
   alut_regs alut_i (
      .hclk    (hclk),
      .rst     (rst),
      .psel    (psel_alut),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr[6:0]),
      .pwdata  (pwdata),
      .prdata  (prdata_alut)
   );

endmodule

/* alut/alut_regs.sv */
// ALUT register block
`timescale 1ns/1ns

module alut_regs (
   input  logic               hclk,
   input  logic               rst,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [6:0]         paddr,
   input  apb_sub_pkg::data_t pwdata,
   output apb_sub_pkg::data_t prdata
);

   // Key table and lookup state
   apb_sub_pkg::data_t key_mem [apb_sub_pkg::ALUT_ENTRIES];
   apb_sub_pkg::data_t search_key;
   logic               search_pend;
   logic               res_hit;
   logic [2:0]         res_idx;

   // Write decode
   logic               wr_en;
   logic               entry_sel;
   logic               key_sel;
   logic               res_sel;

   // Combinational match
   logic               match_hit;
   logic [2:0]         match_idx;

   // ----------------------------------------
   // Register decode
   // ----------------------------------------

   // Write on the access edge since pready is always high here
   assign wr_en = psel && penable && pwrite;

   // Entries sit below the search key with one word each
   assign entry_sel = (paddr < apb_sub_pkg::ALUT_KEY_OFS);
   assign key_sel   = (paddr == apb_sub_pkg::ALUT_KEY_OFS);
   assign res_sel   = (paddr == apb_sub_pkg::ALUT_RES_OFS);

   // ----------------------------------------
   // Lookup
   // ----------------------------------------

   // Scan down so the lowest matching index wins
   always_comb begin
      match_hit = 1'b0;
      match_idx = '0;
      for (int i = apb_sub_pkg::ALUT_ENTRIES - 1; i >= 0; i--) begin
         if (key_mem[i] == search_key) begin
            match_hit = 1'b1;
            match_idx = 3'(i);
         end
      end
   end

   always_ff @(posedge hclk) begin
      if (rst) begin
         for (int i = 0; i < apb_sub_pkg::ALUT_ENTRIES; i++) begin
            key_mem[i] <= '0;
         end
         search_key  <= '0;
         search_pend <= 1'b0;
         res_hit     <= 1'b0;
         res_idx     <= '0;
      end else begin
         // Key write kicks a compare on the next cycle
         search_pend <= wr_en && key_sel;
         if (wr_en && entry_sel) begin
            key_mem[paddr[4:2]] <= pwdata;
         end
         if (wr_en && key_sel) begin
            search_key <= pwdata;
         end
         // Miss leaves index and flag at zero
         if (search_pend) begin
            res_hit <= match_hit;
            res_idx <= match_idx;
         end
      end
   end

   // ----------------------------------------
   // Read back
   // ----------------------------------------

   always_comb begin
      prdata = '0;
      if (entry_sel) begin
         prdata = key_mem[paddr[4:2]];
      end else if (key_sel) begin
         prdata = search_key;
      end else if (res_sel) begin
         prdata[apb_sub_pkg::ALUT_RES_HIT_BIT] = res_hit;
         prdata[2:0]                           = res_idx;
      end
      // Any other offset reads zero
   end

endmodule

/* ahb2apb/apb_slot_router.sv */
// APB slot decode and return mux
`timescale 1ns/1ns

module apb_slot_router (
   input  apb_sub_pkg::addr_t     haddr,
   input  apb_sub_pkg::addr_t     paddr,
   input  logic                   psel_active,
   input  apb_sub_pkg::data_t     prdata_alut,
   input  apb_sub_pkg::data_t     prdata_mac0,
   input  apb_sub_pkg::data_t     prdata_mac1,
   input  apb_sub_pkg::data_t     prdata_mac2,
   input  apb_sub_pkg::data_t     prdata_mac3,
   input  logic                   pready_mac0,
   input  logic                   pready_mac1,
   input  logic                   pready_mac2,
   input  logic                   pready_mac3,
   output logic                   addr_hit,
   output apb_sub_pkg::slot_sel_t psel,
   output apb_sub_pkg::data_t     sel_rdata,
   output logic                   sel_ready
);

   apb_sub_pkg::data_t     rdata_vec [apb_sub_pkg::NUM_SLOTS];
   apb_sub_pkg::slot_sel_t ready_vec;

   // One-hot slot of an address, zero when outside the map
   function automatic apb_sub_pkg::slot_sel_t decode_slot(input apb_sub_pkg::addr_t a);
      logic [31-apb_sub_pkg::SLOT_SPAN_BITS:0] page;
      apb_sub_pkg::slot_sel_t                  sel;
      // Page offset from slot 0
      page = a[31:apb_sub_pkg::SLOT_SPAN_BITS] -
             apb_sub_pkg::SLOT_BASE[31:apb_sub_pkg::SLOT_SPAN_BITS];
      for (int n = 0; n < apb_sub_pkg::NUM_SLOTS; n++) begin
         sel[n] = (int'(page) == n);
      end
      return sel;
   endfunction

   // ----------------------------------------
   // Decode
   // ----------------------------------------

   // AHB address phase, picks APB or error path
   assign addr_hit = |decode_slot(haddr);

   // Registered APB address, only during setup and access
   assign psel = psel_active ? decode_slot(paddr) : '0;

   // ----------------------------------------
   // Return path
   // ----------------------------------------

   assign rdata_vec[0] = prdata_alut;
   assign rdata_vec[1] = prdata_mac0;
   assign rdata_vec[2] = prdata_mac1;
   assign rdata_vec[3] = prdata_mac2;
   assign rdata_vec[4] = prdata_mac3;

   // ALUT never inserts wait states
   assign ready_vec = {pready_mac3, pready_mac2, pready_mac1, pready_mac0, 1'b1};

   // AND-OR mux on the one-hot select
   always_comb begin
      sel_rdata = '0;
      sel_ready = 1'b0;
      for (int n = 0; n < apb_sub_pkg::NUM_SLOTS; n++) begin
         if (psel[n]) begin
            sel_rdata = sel_rdata | rdata_vec[n];
            sel_ready = sel_ready | ready_vec[n];
         end
      end
   end

endmodule

/* ahb2apb/ahb2apb_ctrl.sv */
// AHB to APB bridge control
`timescale 1ns/1ns

module ahb2apb_ctrl (
   input  logic                       hclk,
   input  logic                       rst,
   // AHB-Lite slave side
   input  logic                       hsel,
   input  apb_sub_pkg::addr_t         haddr,
   input  logic [1:0]                 htrans,
   input  logic                       hwrite,
   input  apb_sub_pkg::data_t         hwdata,
   input  logic                       hready_in,
   // From the slot router
   input  logic                       addr_hit,
   input  apb_sub_pkg::data_t         sel_rdata,
   input  logic                       sel_ready,
   // AHB response
   output apb_sub_pkg::data_t         hrdata,
   output logic                       hready,
   output apb_sub_pkg::resp_t         hresp,
   // APB master side
   output apb_sub_pkg::addr_t         paddr,
   output logic                       pwrite,
   output apb_sub_pkg::data_t         pwdata,
   output logic                       penable,
   output logic                       psel_active
);

   apb_sub_pkg::bridge_state_t state;
   apb_sub_pkg::bridge_state_t state_nxt;
   // AHB data phase of an accepted mapped transfer
   logic data_phase;
   logic accept;
   logic apb_start;
   logic apb_done;

   // ----------------------------------------
   // AHB handshake
   // ----------------------------------------

   // Address phase taken only while we are ready
   assign accept = hsel && hready_in && hready &&
                   ((htrans & apb_sub_pkg::HTRANS_NONSEQ) != 2'b00);

   // Low through data phase, APB phases and first error cycle
   assign hready = !(data_phase || state == apb_sub_pkg::st_setup ||
                     state == apb_sub_pkg::st_access || state == apb_sub_pkg::st_err1);

   // ERROR held over both error cycles
   assign hresp = (state == apb_sub_pkg::st_err1 || state == apb_sub_pkg::st_err2) ?
                  apb_sub_pkg::RESP_ERROR : apb_sub_pkg::RESP_OKAY;

   // APB strobes follow the state
   assign apb_start   = (state == apb_sub_pkg::st_idle) && data_phase;
   assign apb_done    = (state == apb_sub_pkg::st_access) && sel_ready;
   assign psel_active = (state == apb_sub_pkg::st_setup) || (state == apb_sub_pkg::st_access);
   assign penable     = (state == apb_sub_pkg::st_access);

   // ----------------------------------------
   // Next state
   // ----------------------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         apb_sub_pkg::st_idle: begin
            if (apb_start) begin
               state_nxt = apb_sub_pkg::st_setup;
            end else if (accept && !addr_hit) begin
               state_nxt = apb_sub_pkg::st_err1;
            end
         end
         apb_sub_pkg::st_setup:  state_nxt = apb_sub_pkg::st_access;
         // Slave wait states keep us here
         apb_sub_pkg::st_access: begin
            if (sel_ready) begin
               state_nxt = apb_sub_pkg::st_idle;
            end
         end
         apb_sub_pkg::st_err1:   state_nxt = apb_sub_pkg::st_err2;
         // hready is high again, a new address phase may land here
         apb_sub_pkg::st_err2: begin
            if (accept && !addr_hit) begin
               state_nxt = apb_sub_pkg::st_err1;
            end else begin
               state_nxt = apb_sub_pkg::st_idle;
            end
         end
         default: state_nxt = apb_sub_pkg::st_idle;
      endcase
   end

   always_ff @(posedge hclk) begin
      if (rst) begin
         state      <= apb_sub_pkg::st_idle;
         data_phase <= 1'b0;
      end else begin
         state      <= state_nxt;
         data_phase <= accept && addr_hit;
      end
   end

   // Address and direction from the AHB address phase
   always_ff @(posedge hclk) begin
      if (accept && addr_hit) begin
         paddr  <= haddr;
         pwrite <= hwrite;
      end
      // hwdata is valid in the data phase
      if (apb_start) begin
         pwdata <= hwdata;
      end
      // Read data on the completing edge
      if (apb_done && !pwrite) begin
         hrdata <= sel_rdata;
      end
   end

endmodule

/* common/apb_sub_pkg.sv */
// APB subsystem shared definitions
package apb_sub_pkg;

   // ----------------------------------------
   // Bus widths
   // ----------------------------------------

   // Byte address, same width on AHB and APB
   typedef logic [31:0] addr_t;
   // Read and write data word
   typedef logic [31:0] data_t;
   // AHB response code
   typedef logic [1:0]  resp_t;

   // ----------------------------------------
   // Slot address map
   // ----------------------------------------

   // ALUT plus MAC0 to MAC3
   localparam int NUM_SLOTS = 5;
   // One-hot select, bit 0 is the ALUT
   typedef logic [NUM_SLOTS-1:0] slot_sel_t;

   // Base of slot 0, slots follow back to back
   localparam addr_t SLOT_BASE = 32'h00A0_0000;
   // 64 KB per slot
   localparam int SLOT_SPAN_BITS = 16;

   // ----------------------------------------
   // AHB encodings
   // ----------------------------------------

   localparam resp_t RESP_OKAY  = 2'b00;
   localparam resp_t RESP_ERROR = 2'b01;
   // Bit 1 set marks an active transfer
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

   // ----------------------------------------
   // ALUT register map
   // ----------------------------------------

   localparam int ALUT_ENTRIES = 8;
   // Keys live below the search key register
   localparam logic [6:0] ALUT_KEY_OFS = 7'h20;
   localparam logic [6:0] ALUT_RES_OFS = 7'h24;
   // Hit flag position, index in bits 2:0
   localparam int ALUT_RES_HIT_BIT = 8;

   // Bridge controller states
   typedef enum logic [2:0] {
      st_idle,
      st_setup,
      st_access,
      st_err1,
      st_err2
   } bridge_state_t;

endpackage
